/* lat_consts.svh */
////////////////////////////////////////
// Widths, depths and delay ranges for the latency model
// Delay maxima must stay below 2**LAT_DELAY_W
// The LFSR seed must be non-zero
////////////////////////////////////////
`ifndef LAT_CONSTS_SVH
`define LAT_CONSTS_SVH

// Payload widths
`define LAT_TAG_W            13
`define LAT_DATA_W           32

// FIFO depth 8 with almost-full at 6 entries
`define LAT_FIFO_DEPTH_LOG2  3
`define LAT_FIFO_AFULL       6

// Slot array size and counter width
`define LAT_NUM_SLOTS        16
`define LAT_DELAY_W          5

// Delay ranges in cycles, both ends inclusive
`define LAT_RDLINE_MIN       4
`define LAT_RDLINE_MAX       15
`define LAT_WRLINE_MIN       2
`define LAT_WRLINE_MAX       9
`define LAT_WRTHRU_MIN       6
`define LAT_WRTHRU_MAX       20
`define LAT_INTR_MIN         1
`define LAT_INTR_MAX         3

// Fallback for kinds without a range
`define LAT_UNDEF_DELAY      12

`define LAT_LFSR_SEED        16'hB5C3

`endif

/* lat_pkg.sv */
////////////////////////////////////////
// Request types for design and testbench
// Kind codes 5 to 7 are undefined kinds
////////////////////////////////////////
`include "lat_consts.svh"

package lat_pkg;

   // Request kind encoding
   typedef enum logic [2:0] {
      rdline  = 3'd0,
      wrline  = 3'd1,
      wrthru  = 3'd2,
      wrfence = 3'd3,
      intr    = 3'd4
   } req_kind_t;

   // Request header of 16 bits
   typedef struct packed {
      req_kind_t             kind;
      logic [`LAT_TAG_W-1:0] tag;
   } meta_t;

   typedef logic [`LAT_DATA_W-1:0] data_t;

   // Slot index and countdown value
   typedef logic [$clog2(`LAT_NUM_SLOTS)-1:0] slot_idx_t;
   typedef logic [`LAT_DELAY_W-1:0] delay_t;

endpackage

/* lat_fifo.sv */
////////////////////////////////////////
// Show-ahead FIFO of 2**LAT_FIFO_DEPTH_LOG2 entries
// Write when full or pop when empty is dropped
// and flagged by a one-cycle pulse
////////////////////////////////////////
`include "lat_consts.svh"

module lat_fifo import lat_pkg::*; (
   input  logic  clk,
   input  logic  rst,
   input  logic  wr_en_i,
   input  meta_t wr_meta_i,
   input  data_t wr_data_i,
   input  logic  rd_en_i,
   output meta_t rd_meta_o,
   output data_t rd_data_o,
   output logic  empty_o,
   output logic  afull_o,
   output logic  overflow_o,
   output logic  underflow_o
);

   localparam int PTR_W = `LAT_FIFO_DEPTH_LOG2;
   localparam int DEPTH = 1 << PTR_W;

   // Storage
   meta_t mem_meta [DEPTH];
   data_t mem_data [DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   // One extra bit so a full FIFO is distinct from empty
   logic [PTR_W:0]   count;
   logic             full;
   logic             wr_ok;
   logic             rd_ok;

   assign full    = (count == (PTR_W+1)'(DEPTH));
   assign empty_o = (count == '0);
   assign afull_o = (count >= (PTR_W+1)'(`LAT_FIFO_AFULL));

   // Accepted operations only
   assign wr_ok = wr_en_i && !full;
   assign rd_ok = rd_en_i && !empty_o;

   // Head is read straight from the array
   assign rd_meta_o = mem_meta[rd_ptr];
   assign rd_data_o = mem_data[rd_ptr];

   // Pointers, occupancy and error pulses
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         count       <= '0;
         overflow_o  <= 1'b0;
         underflow_o <= 1'b0;
      end else begin
         overflow_o  <= wr_en_i && full;
         underflow_o <= rd_en_i && empty_o;
         if (wr_ok) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_ok) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // Simultaneous push and pop keep the count
         case ({wr_ok, rd_ok})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Payload write
   always_ff @(posedge clk) begin
      if (wr_ok) begin
         mem_meta[wr_ptr] <= wr_meta_i;
         mem_data[wr_ptr] <= wr_data_i;
      end
   end

endmodule

/* lat_fence_gate.sv */
////////////////////////////////////////
// Moves input FIFO heads into the slot array
// At most one push per cycle
// A write fence is popped once the array drains
////////////////////////////////////////

module lat_fence_gate import lat_pkg::*; (
   input  logic  clk,
   input  logic  rst,
   input  meta_t head_meta_i,
   input  data_t head_data_i,
   input  logic  head_empty_i,
   input  logic  array_full_i,
   input  logic  array_empty_i,
   output logic  head_pop_o,
   output logic  push_o,
   output meta_t push_meta_o,
   output data_t push_data_o
);

   // Push control states
   typedef enum logic [1:0] {
      st_pass       = 2'd0,
      st_fence_wait = 2'd1,
      st_fence_drop = 2'd2
   } gate_state_t;

   gate_state_t state_q;
   gate_state_t state_d;
   logic        head_is_fence;

   assign head_is_fence = !head_empty_i && (head_meta_i.kind == wrfence);

   // Slot array loads the head at the edge that pops it
   assign push_meta_o = head_meta_i;
   assign push_data_o = head_data_i;

   always_comb begin
      state_d    = state_q;
      push_o     = 1'b0;
      head_pop_o = 1'b0;
      case (state_q)
         st_pass: begin
            if (head_is_fence) begin
               // Hold back everything behind the fence
               state_d = st_fence_wait;
            end else if (!head_empty_i && !array_full_i) begin
               push_o     = 1'b1;
               head_pop_o = 1'b1;
            end
         end
         st_fence_wait: begin
            // All earlier requests gone from the slots
            if (array_empty_i) begin
               state_d = st_fence_drop;
            end
         end
         st_fence_drop: begin
            // Discard the fence without a push
            head_pop_o = 1'b1;
            state_d    = st_pass;
         end
         default: begin
            state_d = st_pass;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= st_pass;
      end else begin
         state_q <= state_d;
      end
   end

endmodule

/* lat_delay_gen.sv */
////////////////////////////////////////
// Pseudo-random delay per request kind
// The LFSR steps every cycle whether used or not
// Wrfence and undefined kinds get LAT_UNDEF_DELAY
////////////////////////////////////////
`include "lat_consts.svh"

module lat_delay_gen import lat_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  req_kind_t kind_i,
   output delay_t    delay_o
);

   logic [15:0] lfsr_q;
   logic        feedback;
   logic [7:0]  rnd;

   // Taps for x^16 + x^14 + x^13 + x^11 + 1
   assign feedback = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
   assign rnd      = lfsr_q[7:0];

   always_ff @(posedge clk) begin
      if (rst) begin
         lfsr_q <= `LAT_LFSR_SEED;
      end else begin
         lfsr_q <= {lfsr_q[14:0], feedback};
      end
   end

   // Fold the random byte into lo..hi
   function automatic delay_t pick(input logic [7:0] r,
                                   input int unsigned lo,
                                   input int unsigned hi);
      int unsigned span;
      span = hi - lo + 1;
      return delay_t'(lo + (r % span));
   endfunction

   always_comb begin
      case (kind_i)
         rdline:  delay_o = pick(rnd, `LAT_RDLINE_MIN, `LAT_RDLINE_MAX);
         wrline:  delay_o = pick(rnd, `LAT_WRLINE_MIN, `LAT_WRLINE_MAX);
         wrthru:  delay_o = pick(rnd, `LAT_WRTHRU_MIN, `LAT_WRTHRU_MAX);
         intr:    delay_o = pick(rnd, `LAT_INTR_MIN, `LAT_INTR_MAX);
         // Fence and undefined kinds share the fallback
         default: delay_o = delay_t'(`LAT_UNDEF_DELAY);
      endcase
   end

endmodule

/* lat_slot_array.sv */
////////////////////////////////////////
// LAT_NUM_SLOTS request slots with countdown
// Push needs a free slot and the caller checks array_full_o
// Release is one per cycle while the output FIFO is below almost-full
////////////////////////////////////////
`include "lat_consts.svh"

module lat_slot_array import lat_pkg::*; (
   input  logic   clk,
   input  logic   rst,
   input  logic   push_i,
   input  meta_t  push_meta_i,
   input  data_t  push_data_i,
   input  delay_t push_delay_i,
   input  logic   out_afull_i,
   output logic   array_full_o,
   output logic   array_empty_o,
   output logic   out_wr_o,
   output meta_t  out_meta_o,
   output data_t  out_data_o
);

   localparam int N = `LAT_NUM_SLOTS;

   // Slot records
   meta_t  slot_meta [N];
   data_t  slot_data [N];
   delay_t slot_cnt  [N];
   // Slot holds a request
   logic [N-1:0] busy_q;
   // Countdown finished and waiting for release
   logic [N-1:0] ready_q;

   slot_idx_t free_idx;
   slot_idx_t rel_idx;
   logic      do_push;
   logic      do_release;

   // Priority search for the lowest set bit
   // Scans from the top so the lowest index is written last
   function automatic slot_idx_t lowest_idx(input logic [N-1:0] vec);
      slot_idx_t idx;
      idx = '0;
      for (int i = N - 1; i >= 0; i--) begin
         if (vec[i]) begin
            idx = slot_idx_t'(i);
         end
      end
      return idx;
   endfunction

   assign free_idx = lowest_idx(~busy_q);
   assign rel_idx  = lowest_idx(ready_q);

   assign array_full_o  = &busy_q;
   assign array_empty_o = ~|busy_q;

   // Guard against a push into a full array
   assign do_push    = push_i && !array_full_o;
   // Back-pressure from the output FIFO
   assign do_release = (|ready_q) && !out_afull_i;

   // Slot state and countdown
   always_ff @(posedge clk) begin
      if (rst) begin
         busy_q   <= '0;
         ready_q  <= '0;
         out_wr_o <= 1'b0;
         for (int i = 0; i < N; i++) begin
            slot_cnt[i] <= '0;
         end
      end else begin
         out_wr_o <= do_release;

         // Count down, then mark ready one cycle after zero
         for (int i = 0; i < N; i++) begin
            if (busy_q[i] && !ready_q[i]) begin
               if (slot_cnt[i] == '0) begin
                  ready_q[i] <= 1'b1;
               end else begin
                  slot_cnt[i] <= slot_cnt[i] - 1'b1;
               end
            end
         end

         // Freed slot becomes usable next cycle
         if (do_release) begin
            busy_q[rel_idx]  <= 1'b0;
            ready_q[rel_idx] <= 1'b0;
         end

         // Push and release never hit the same slot
         if (do_push) begin
            busy_q[free_idx]   <= 1'b1;
            ready_q[free_idx]  <= 1'b0;
            slot_cnt[free_idx] <= push_delay_i;
         end
      end
   end

   // Payload capture and registered release toward the output FIFO
   always_ff @(posedge clk) begin
      if (do_push) begin
         slot_meta[free_idx] <= push_meta_i;
         slot_data[free_idx] <= push_data_i;
      end
      if (do_release) begin
         out_meta_o <= slot_meta[rel_idx];
         out_data_o <= slot_data[rel_idx];
      end
   end

endmodule

/* lat_scoreboard_top.sv */
////////////////////////////////////////
// Latency model for a coherent request channel
// Requests leave reordered after a random delay
// Sender must hold write_en_i low while full_o is high
////////////////////////////////////////

module lat_scoreboard_top import lat_pkg::*; (
   input  logic  clk,
   input  logic  rst,
   input  logic  write_en_i,
   input  meta_t meta_i,
   input  data_t data_i,
   input  logic  read_en_i,
   output meta_t meta_o,
   output data_t data_o,
   output logic  valid_o,
   output logic  empty_o,
   output logic  full_o,
   output logic  overflow_o,
   output logic  underflow_o
);

   // Input FIFO head
   meta_t  in_meta;
   data_t  in_data;
   logic   in_empty;
   logic   in_pop;
   logic   in_ovf;
   logic   in_udf;

   // Fence gate to slot array
   logic   push;
   meta_t  push_meta;
   data_t  push_data;
   delay_t push_delay;
   logic   arr_full;
   logic   arr_empty;

   // Slot array to output FIFO
   logic   out_wr;
   meta_t  out_meta;
   data_t  out_data;
   logic   out_afull;
   logic   out_empty;
   logic   out_ovf;
   logic   out_udf;

   lat_fifo u_in_fifo (
      .clk         (clk),
      .rst         (rst),
      .wr_en_i     (write_en_i),
      .wr_meta_i   (meta_i),
      .wr_data_i   (data_i),
      .rd_en_i     (in_pop),
      .rd_meta_o   (in_meta),
      .rd_data_o   (in_data),
      .empty_o     (in_empty),
      .afull_o     (full_o),
      .overflow_o  (in_ovf),
      .underflow_o (in_udf)
   );

   lat_fence_gate u_fence_gate (
      .clk           (clk),
      .rst           (rst),
      .head_meta_i   (in_meta),
      .head_data_i   (in_data),
      .head_empty_i  (in_empty),
      .array_full_i  (arr_full),
      .array_empty_i (arr_empty),
      .head_pop_o    (in_pop),
      .push_o        (push),
      .push_meta_o   (push_meta),
      .push_data_o   (push_data)
   );

   // Delay follows the current head kind
   lat_delay_gen u_delay_gen (
      .clk     (clk),
      .rst     (rst),
      .kind_i  (in_meta.kind),
      .delay_o (push_delay)
   );

   lat_slot_array u_slot_array (
      .clk           (clk),
      .rst           (rst),
      .push_i        (push),
      .push_meta_i   (push_meta),
      .push_data_i   (push_data),
      .push_delay_i  (push_delay),
      .out_afull_i   (out_afull),
      .array_full_o  (arr_full),
      .array_empty_o (arr_empty),
      .out_wr_o      (out_wr),
      .out_meta_o    (out_meta),
      .out_data_o    (out_data)
   );

   lat_fifo u_out_fifo (
      .clk         (clk),
      .rst         (rst),
      .wr_en_i     (out_wr),
      .wr_meta_i   (out_meta),
      .wr_data_i   (out_data),
      .rd_en_i     (read_en_i),
      .rd_meta_o   (meta_o),
      .rd_data_o   (data_o),
      .empty_o     (out_empty),
      .afull_o     (out_afull),
      .overflow_o  (out_ovf),
      .underflow_o (out_udf)
   );

   assign empty_o = out_empty;
   assign valid_o = !out_empty;

   // Error flags from both FIFOs
   assign overflow_o  = in_ovf | out_ovf;
   assign underflow_o = in_udf | out_udf;

endmodule

/* tb_lat_scoreboard.sv */
////////////////////////////////////////
// Directed testbench for lat_scoreboard_top
// Tags are unique up to 2**LAT_TAG_W requests per run
// Back-pressure test sends until full_o or BP_MAX requests
////////////////////////////////////////
`include "lat_consts.svh"

module tb_lat_scoreboard import lat_pkg::*; ();

   // Run limit of 500 cycles per test
   localparam int NUM_TESTS   = 6;
   localparam int TEST_CYCLES = 500;
   localparam int CYCLE_LIMIT = NUM_TESTS * TEST_CYCLES;
   localparam int TAGS        = 1 << `LAT_TAG_W;
   // full_o rises after about 30 requests fill slots and both FIFOs
   localparam int BP_MAX      = 40;

   logic  clk;
   logic  rst;
   logic  write_en_i;
   meta_t meta_i;
   data_t data_i;
   logic  read_en_i;
   meta_t meta_o;
   data_t data_o;
   logic  valid_o;
   logic  empty_o;
   logic  full_o;
   logic  overflow_o;
   logic  underflow_o;

   // Sent-request table indexed by tag
   meta_t exp_meta   [TAGS];
   data_t exp_data   [TAGS];
   int    sent_cycle [TAGS];
   bit    sent_flag  [TAGS];
   bit    got_flag   [TAGS];
   int    out_order  [$];

   integer seed;
   int     next_tag;
   int     cycle;
   int     rx_count;
   int     err_count;
   int     err_at_start;
   int     tests_run;
   int     tests_failed;
   bit     saw_full;
   bit     saw_ovf;
   string  cur_test;

   lat_scoreboard_top u_lat_scoreboard_top (
      .clk         (clk),
      .rst         (rst),
      .write_en_i  (write_en_i),
      .meta_i      (meta_i),
      .data_i      (data_i),
      .read_en_i   (read_en_i),
      .meta_o      (meta_o),
      .data_o      (data_o),
      .valid_o     (valid_o),
      .empty_o     (empty_o),
      .full_o      (full_o),
      .overflow_o  (overflow_o),
      .underflow_o (underflow_o)
   );

   always #5 clk = ~clk;

   // Lower bound of a kind's delay range
   function automatic int min_delay(input req_kind_t kind);
      case (kind)
         rdline:  return `LAT_RDLINE_MIN;
         wrline:  return `LAT_WRLINE_MIN;
         wrthru:  return `LAT_WRTHRU_MIN;
         intr:    return `LAT_INTR_MIN;
         default: return `LAT_UNDEF_DELAY;
      endcase
   endfunction

   // Random non-fence kind including undefined codes
   function automatic req_kind_t rand_kind();
      logic [2:0] k;
      k = 3'($random(seed));
      if (k == 3'd3) begin
         k = 3'd0;
      end
      return req_kind_t'(k);
   endfunction

   task automatic check_meta(input meta_t exp, input meta_t act);
      if (act !== exp) begin
         err_count++;
         $display("error: %s meta expected %h actual %h", cur_test, exp, act);
      end
   endtask

   task automatic check_data(input data_t exp, input data_t act);
      if (act !== exp) begin
         err_count++;
         $display("error: %s data expected %h actual %h", cur_test, exp, act);
      end
   endtask

   task automatic check_bit(input logic exp, input logic act, input string what);
      if (act !== exp) begin
         err_count++;
         $display("error: %s %s expected %b actual %b", cur_test, what, exp, act);
      end
   endtask

   task automatic check_count(input int exp, input int act, input string what);
      if (act != exp) begin
         err_count++;
         $display("error: %s %s expected %0d actual %0d", cur_test, what, exp, act);
      end
   endtask

   // One popped output against the sent table
   task automatic record_output(input meta_t m, input data_t d);
      int lat;
      int lo;
      lat = cycle - sent_cycle[m.tag];
      lo  = min_delay(m.kind) + 3;
      if (m.kind == wrfence) begin
         err_count++;
         $display("%s: a write fence appeared at meta_o", cur_test);
      end else if (!sent_flag[m.tag]) begin
         err_count++;
         $display("%s: tag %0d came out but was never sent", cur_test, m.tag);
      end else if (got_flag[m.tag]) begin
         err_count++;
         $display("%s: tag %0d came out twice", cur_test, m.tag);
      end else begin
         got_flag[m.tag] = 1'b1;
         check_meta(exp_meta[m.tag], m);
         check_data(exp_data[m.tag], d);
         if (lat < lo) begin
            err_count++;
            $display("error: %s latency of tag %0d expected at least %0d actual %0d",
                     cur_test, m.tag, lo, lat);
         end
         out_order.push_back(m.tag);
         rx_count++;
      end
   endtask

   // Collector for writes, pops and status levels
   always @(posedge clk) begin
      if (!rst) begin
         // Edge at which the input FIFO takes the write
         if (write_en_i) begin
            sent_cycle[meta_i.tag] = cycle;
         end
         if (full_o) begin
            saw_full = 1'b1;
         end
         if (overflow_o) begin
            saw_ovf = 1'b1;
         end
         if (read_en_i && valid_o) begin
            record_output(meta_o, data_o);
         end
      end
      cycle = cycle + 1;
   end

   // Drive one request right after a rising edge
   task automatic drive_req(input req_kind_t kind, input data_t data);
      meta_t m;
      m.kind = kind;
      m.tag  = next_tag[`LAT_TAG_W-1:0];
      if (kind != wrfence) begin
         exp_meta[m.tag]  = m;
         exp_data[m.tag]  = data;
         sent_flag[m.tag] = 1'b1;
      end
      meta_i     <= m;
      data_i     <= data;
      write_en_i <= 1'b1;
      next_tag++;
   endtask

   // Holds off while the input FIFO is almost full
   task automatic send_req(input req_kind_t kind, input data_t data);
      @(posedge clk);
      while (full_o) begin
         write_en_i <= 1'b0;
         @(posedge clk);
      end
      drive_req(kind, data);
   endtask

   task automatic end_writes();
      @(posedge clk);
      write_en_i <= 1'b0;
   endtask

   // Waits n falling edges
   task automatic idle_cycles(input int n);
      repeat (n) @(negedge clk);
   endtask

   task automatic wait_outputs(input int target, input int limit);
      int waited;
      waited = 0;
      while (rx_count < target && waited < limit) begin
         @(negedge clk);
         waited++;
      end
      if (rx_count < target) begin
         err_count++;
         $display("%s: only %0d of %0d outputs arrived within %0d cycles",
                  cur_test, rx_count, target, limit);
      end
   endtask

   task automatic clear_flags();
      @(negedge clk);
      saw_full = 1'b0;
      saw_ovf  = 1'b0;
   endtask

   task automatic begin_test(input string name);
      cur_test     = name;
      err_at_start = err_count;
   endtask

   task automatic end_test();
      tests_run++;
      if (err_count == err_at_start) begin
         $display("%s: passed", cur_test);
      end else begin
         tests_failed++;
         $display("%s: failed with %0d errors", cur_test, err_count - err_at_start);
      end
   endtask

   task automatic test_reset_state();
      begin_test("reset_state");
      @(negedge clk);
      check_bit(1'b1, empty_o, "empty_o");
      check_bit(1'b0, valid_o, "valid_o");
      check_bit(1'b0, full_o, "full_o");
      check_bit(1'b0, overflow_o, "overflow_o");
      check_bit(1'b0, underflow_o, "underflow_o");
      end_test();
   endtask

   // One request per kind, each drained before the next
   task automatic test_each_kind();
      req_kind_t kinds [5];
      int        target;
      kinds = '{rdline, wrline, wrthru, intr, req_kind_t'(3'd5)};
      begin_test("each_kind");
      @(posedge clk);
      read_en_i <= 1'b1;
      for (int i = 0; i < 5; i++) begin
         target = rx_count + 1;
         send_req(kinds[i], data_t'($random(seed)));
         end_writes();
         wait_outputs(target, 200);
      end
      end_test();
   endtask

   task automatic test_burst();
      int base;
      begin_test("burst");
      clear_flags();
      base = rx_count;
      for (int i = 0; i < 12; i++) begin
         send_req(rand_kind(), data_t'($random(seed)));
      end
      end_writes();
      wait_outputs(base + 12, 400);
      idle_cycles(30);
      check_count(12, rx_count - base, "output count");
      check_bit(1'b0, saw_ovf, "overflow_o seen");
      end_test();
   endtask

   task automatic test_fence();
      int base;
      int first;
      int fence_tag;
      begin_test("fence");
      base  = rx_count;
      first = out_order.size();
      // Long delays before the fence and short ones after
      for (int i = 0; i < 4; i++) begin
         send_req(wrthru, data_t'($random(seed)));
      end
      fence_tag = next_tag;
      send_req(wrfence, data_t'($random(seed)));
      for (int i = 0; i < 4; i++) begin
         send_req(intr, data_t'($random(seed)));
      end
      end_writes();
      wait_outputs(base + 8, 400);
      idle_cycles(30);
      check_count(8, rx_count - base, "output count");
      // First four outputs must all be older than the fence
      for (int i = first; i < first + 4 && i < out_order.size(); i++) begin
         if (out_order[i] > fence_tag) begin
            err_count++;
            $display("error: %s output %0d expected tag below %0d actual %0d",
                     cur_test, i - first, fence_tag, out_order[i]);
         end
      end
      end_test();
   endtask

   // Output stalled until the whole chain backs up
   task automatic test_backpressure();
      int base;
      int sent;
      bit full_seen;
      begin_test("backpressure");
      @(posedge clk);
      read_en_i <= 1'b0;
      clear_flags();
      base      = rx_count;
      sent      = 0;
      full_seen = 1'b0;
      while (!full_seen && sent < BP_MAX) begin
         @(posedge clk);
         if (full_o) begin
            full_seen  = 1'b1;
            write_en_i <= 1'b0;
         end else begin
            drive_req(rand_kind(), data_t'($random(seed)));
            sent++;
         end
      end
      end_writes();
      idle_cycles(100);
      check_bit(1'b1, saw_full, "full_o seen");
      check_bit(1'b1, full_o, "full_o after stall");
      check_count(0, rx_count - base, "outputs while stalled");
      @(posedge clk);
      read_en_i <= 1'b1;
      wait_outputs(base + sent, 400);
      idle_cycles(30);
      check_count(sent, rx_count - base, "output count");
      check_bit(1'b0, saw_ovf, "overflow_o seen");
      end_test();
   endtask

   task automatic test_underflow();
      begin_test("underflow");
      @(posedge clk);
      read_en_i <= 1'b0;
      idle_cycles(3);
      check_bit(1'b1, empty_o, "empty_o before pop");
      check_bit(1'b0, underflow_o, "underflow_o before pop");
      @(posedge clk);
      read_en_i <= 1'b1;
      // Pop on an empty FIFO is taken at this edge
      @(posedge clk);
      read_en_i <= 1'b0;
      @(negedge clk);
      check_bit(1'b1, underflow_o, "underflow_o after pop");
      check_bit(1'b1, empty_o, "empty_o after pop");
      @(negedge clk);
      check_bit(1'b0, underflow_o, "underflow_o one cycle later");
      check_bit(1'b1, empty_o, "empty_o one cycle later");
      end_test();
   endtask

   // Run limit
   initial begin
      repeat (CYCLE_LIMIT) @(posedge clk);
      $display("timeout: run stopped after %0d cycles", CYCLE_LIMIT);
      $display("STATUS: FAIL");
      $finish;
   end

   initial begin
      clk          = 1'b0;
      rst          = 1'b1;
      write_en_i   = 1'b0;
      meta_i       = '0;
      data_i       = '0;
      read_en_i    = 1'b0;
      seed         = 91279;
      next_tag     = 0;
      cycle        = 0;
      rx_count     = 0;
      err_count    = 0;
      tests_run    = 0;
      tests_failed = 0;
      saw_full     = 1'b0;
      saw_ovf      = 1'b0;
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      test_reset_state();
      test_each_kind();
      test_burst();
      test_fence();
      test_backpressure();
      test_underflow();
      idle_cycles(5);
      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
      if (err_count == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

/* vlog.f */
+incdir+.
lat_pkg.sv
lat_fifo.sv
lat_fence_gate.sv
lat_delay_gen.sv
lat_slot_array.sv
lat_scoreboard_top.sv
tb_lat_scoreboard.sv

/* Bender.yml */
package:
  name: lat_scoreboard

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - lat_pkg.sv
      - lat_fifo.sv
      - lat_fence_gate.sv
      - lat_delay_gen.sv
      - lat_slot_array.sv
      - lat_scoreboard_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_lat_scoreboard.sv
